//--- objPkg.sv
//--------------------
// Sprite attribute word layout and its two views
// Tile and row types, ROM and CPU address widths
//--------------------

package objPkg;

	localparam int attrAddrWidth = 9;   // 512 CPU bytes
	localparam int romAddrWidth  = 17;  // {tile, row in tile, word}
	localparam int romDataWidth  = 16;  // Four 4-bit pixels per word

	typedef logic [10:0] tileNum;       // {tileHi, tileLo}
	typedef logic [4:0]  objRow;        // Row 0..31 within a sprite

	// Field view, byte 3 down to byte 0
	typedef struct packed {
		logic [7:0] xPos;               // Byte 3
		logic [7:0] tileLo;             // Byte 2
		logic       doubleHeight;       // Byte 1 bit 7
		logic       flipX;
		logic [2:0] palette;
		logic [2:0] tileHi;
		logic [7:0] yPos;               // Byte 0
	} objFields;

	// One attribute word, seen as CPU bytes or as sprite fields
	typedef union packed {
		logic [3:0][7:0] bytes;
		objFields        f;
	} objAttr;

endpackage

//--- videoPkg.sv
//--------------------
// Line geometry, pixel and line-buffer entry types
//--------------------

package videoPkg;

	localparam int lineWidth = 256;     // One buffer entry per x

	typedef logic [7:0] xCoord;         // Wraps modulo 256
	typedef logic [3:0] pixelColor;

	// {palette 3, color 4}
	typedef logic [6:0] lineEntry;

	localparam pixelColor transparent = 4'd0;
	localparam lineEntry  emptyEntry  = 7'd0;   // Nothing drawn here

endpackage

//--- objAttrRam.sv
//--------------------
// Sprite attribute RAM
// CPU byte port and word-wide scan port
//--------------------

module objAttrRam #(
	parameter int numObj = 128
) (
	input  logic                             clk,
	input  logic                             cpuSel,
	input  logic                             cpuWe,
	input  logic [objPkg::attrAddrWidth-1:0] cpuAddr,
	input  logic [7:0]                       cpuWrData,
	input  logic [$clog2(numObj)-1:0]        scanIndex,
	output logic [7:0]                       cpuRdData,
	output objPkg::objAttr                   scanAttr
);

	localparam int idxWidth = $clog2(numObj);

	// One word per sprite, four byte lanes
	objPkg::objAttr attrMem [numObj];

	logic [idxWidth-1:0] cpuIdx;
	logic [1:0]          cpuLane;

	assign cpuIdx  = cpuAddr[idxWidth+1:2];  // Upper bits alias for small numObj
	assign cpuLane = cpuAddr[1:0];

	always_ff @(posedge clk) begin
		// Byte write into the selected lane only
		if (cpuSel && cpuWe) begin
			attrMem[cpuIdx].bytes[cpuLane] <= cpuWrData;
		end
		// Registered CPU read back
		if (cpuSel && !cpuWe) begin
			cpuRdData <= attrMem[cpuIdx].bytes[cpuLane];
		end
		// Scanner gets the whole word one cycle later
		scanAttr <= attrMem[scanIndex];
	end

endmodule

//--- objLineScanner.sv
//--------------------
// Per-line sprite scan
// Vertical hit test and draw job issue
//--------------------

module objLineScanner #(
	parameter int numObj = 128
) (
	input  logic                      clk,
	input  logic                      reset,
	input  logic                      lineStart,
	input  logic [7:0]                lineNum,
	input  objPkg::objAttr            scanAttr,
	input  logic                      drawAck,
	output logic [$clog2(numObj)-1:0] scanIndex,
	output logic                      drawReq,
	output objPkg::tileNum            drawTile,
	output objPkg::objRow             drawRow,
	output logic [2:0]                drawPalette,
	output logic                      drawFlip,
	output videoPkg::xCoord           drawX,
	output logic                      lineDone
);

	localparam int idxWidth = $clog2(numObj);

	localparam logic [2:0] sIdle    = 3'd0;
	localparam logic [2:0] sRead    = 3'd1;   // Address out, RAM latency
	localparam logic [2:0] sTest    = 3'd2;   // Attribute valid
	localparam logic [2:0] sWaitAck = 3'd3;
	localparam logic [2:0] sWaitRel = 3'd4;

	logic [2:0] state;
	logic [7:0] lineReg;
	logic [7:0] rowSum;
	logic       hit;
	logic       lastObj;
	logic       advance;

	// --------------------
	// Vertical hit test
	assign rowSum  = lineReg + scanAttr.f.yPos;   // Wraps mod 256
	assign hit     = (rowSum[7:5] == 3'd0) && (!rowSum[4] || scanAttr.f.doubleHeight);
	assign lastObj = (scanIndex == idxWidth'(numObj - 1));

	// Move on after a miss, or once the fetcher has released
	assign advance = ((state == sTest) && !hit) || ((state == sWaitRel) && !drawAck);

	// --------------------
	// Sequencer
	always_ff @(posedge clk) begin
		if (reset) begin
			state     <= sIdle;
			scanIndex <= '0;
			drawReq   <= 1'b0;
			lineDone  <= 1'b0;
		end else begin
			lineDone <= 1'b0;
			case (state)
				sIdle: if (lineStart) begin
					scanIndex <= '0;
					state     <= sRead;
				end
				sRead: state <= sTest;
				sTest: if (hit) begin
					drawReq <= 1'b1;   // Stall here until job done
					state   <= sWaitAck;
				end
				sWaitAck: if (drawAck) begin
					drawReq <= 1'b0;
					state   <= sWaitRel;
				end
				default: ;
			endcase
			if (advance) begin
				if (lastObj) begin
					lineDone <= 1'b1;
					state    <= sIdle;
				end else begin
					scanIndex <= scanIndex + 1'b1;
					state     <= sRead;
				end
			end
		end
	end

	// Line number and job fields, held while drawReq is up
	always_ff @(posedge clk) begin
		if (state == sIdle && lineStart) lineReg <= lineNum;
		if (state == sTest && hit) begin
			drawTile    <= {scanAttr.f.tileHi, scanAttr.f.tileLo};
			drawRow     <= rowSum[4:0];
			drawPalette <= scanAttr.f.palette;
			drawFlip    <= scanAttr.f.flipX;
			drawX       <= scanAttr.f.xPos;
		end
	end

endmodule

//--- objPixelFetch.sv
//--------------------
// Sprite row fetch from graphics ROM
// Pixel unpack into line buffer writes
//--------------------

module objPixelFetch (
	input  logic                            clk,
	input  logic                            reset,
	input  logic                            drawReq,
	input  objPkg::tileNum                  drawTile,
	input  objPkg::objRow                   drawRow,
	input  logic [2:0]                      drawPalette,
	input  logic                            drawFlip,
	input  videoPkg::xCoord                 drawX,
	input  logic                            romAck,
	input  logic [objPkg::romDataWidth-1:0] romData,
	output logic                            drawAck,
	output logic                            romReq,
	output logic [objPkg::romAddrWidth-1:0] romAddr,
	output logic                            wrEn,
	output videoPkg::xCoord                 wrX,
	output videoPkg::lineEntry              wrEntry
);

	localparam logic [2:0] sIdle = 3'd0;
	localparam logic [2:0] sReq  = 3'd1;   // Wait for romAck low, then request
	localparam logic [2:0] sAck  = 3'd2;
	localparam logic [2:0] sPix  = 3'd3;   // One nibble per cycle
	localparam logic [2:0] sDone = 3'd4;

	logic [2:0]                      state;
	logic [1:0]                      wordIdx;
	logic [1:0]                      nibble;
	objPkg::tileNum                  jobTile;
	logic [3:0]                      jobRow;
	logic [objPkg::romDataWidth-1:0] romWord;
	logic [3:0]                      pixelIdx;
	logic [3:0]                      offset;
	videoPkg::pixelColor             color;

	assign romAddr  = {jobTile, jobRow, wordIdx};   // Stable through each request
	assign pixelIdx = {wordIdx, nibble};            // Pixel 0..15 of the row
	assign color    = romWord[{nibble, 2'b00} +: 4];
	assign offset   = drawFlip ? ~pixelIdx : pixelIdx;   // 15 - p when mirrored

	// Job fields are held by the scanner until drawAck
	assign wrX     = drawX + videoPkg::xCoord'(offset);
	assign wrEntry = {drawPalette, color};
	assign wrEn    = (state == sPix) && (color != videoPkg::transparent);

	// --------------------
	// Handshake FSM
	always_ff @(posedge clk) begin
		if (reset) begin
			state   <= sIdle;
			wordIdx <= 2'd0;
			nibble  <= 2'd0;
			romReq  <= 1'b0;
			drawAck <= 1'b0;
		end else begin
			case (state)
				sIdle: if (drawReq) begin
					wordIdx <= 2'd0;
					state   <= sReq;
				end
				sReq: if (!romAck) begin
					romReq <= 1'b1;
					state  <= sAck;
				end
				sAck: if (romAck) begin
					romReq <= 1'b0;   // Model drops romAck next
					nibble <= 2'd0;
					state  <= sPix;
				end
				sPix: begin
					nibble <= nibble + 1'b1;
					if (nibble == 2'd3) begin
						if (wordIdx == 2'd3) begin
							drawAck <= 1'b1;   // Whole row written
							state   <= sDone;
						end else begin
							wordIdx <= wordIdx + 1'b1;
							state   <= sReq;
						end
					end
				end
				sDone: if (!drawReq) begin
					drawAck <= 1'b0;
					state   <= sIdle;
				end
				default: state <= sIdle;
			endcase
		end
	end

	// Tile and row in tile, lower half of a double-height sprite is tile + 1
	always_ff @(posedge clk) begin
		if (state == sIdle && drawReq) begin
			jobTile <= drawTile + objPkg::tileNum'(drawRow[4]);
			jobRow  <= drawRow[3:0];
		end
		if (state == sAck && romAck) romWord <= romData;
	end

endmodule

//--- objLineBuffer.sv
//--------------------
// Ping-pong line buffers
// Draw port and clear-on-read display port
//--------------------

module objLineBuffer (
	input  logic               clk,
	input  logic               reset,
	input  logic               lineStart,
	input  logic               wrEn,
	input  videoPkg::xCoord    wrX,
	input  videoPkg::lineEntry wrEntry,
	input  logic               dispEn,
	input  videoPkg::xCoord    dispX,
	output videoPkg::lineEntry objPixel
);

	logic               drawSel;     // Buffer being drawn
	logic               shownQ;      // Buffer read last cycle
	logic               dispEnQ;
	videoPkg::lineEntry rdData [2];

	// --------------------
	// Buffers, one write port each
	for (genvar b = 0; b < 2; b++) begin : gBuf
		videoPkg::lineEntry lineMem [videoPkg::lineWidth];

		always_ff @(posedge clk) begin
			if (drawSel == 1'(b)) begin
				if (wrEn) lineMem[wrX] <= wrEntry;
			end else if (dispEn) begin
				rdData[b]      <= lineMem[dispX];
				lineMem[dispX] <= videoPkg::emptyEntry;   // Ready for next draw
			end
		end
	end

	// --------------------
	// Select and display control
	always_ff @(posedge clk) begin
		if (reset) begin
			drawSel <= 1'b0;
			shownQ  <= 1'b1;
			dispEnQ <= 1'b0;
		end else begin
			if (lineStart) drawSel <= ~drawSel;   // Swap on every line
			shownQ  <= ~drawSel;
			dispEnQ <= dispEn;
		end
	end

	assign objPixel = dispEnQ ? rdData[shownQ] : videoPkg::emptyEntry;

endmodule

//--- objTop.sv
//--------------------
// Sprite engine top level
//--------------------

module objTop #(
	parameter int numObj = 128
) (
	input  logic                            clk,
	input  logic                            reset,
	input  logic                            cpuSel,
	input  logic                            cpuWe,
	input  logic [objPkg::attrAddrWidth-1:0] cpuAddr,
	input  logic [7:0]                      cpuWrData,
	input  logic                            lineStart,
	input  logic [7:0]                      lineNum,
	input  logic                            dispEn,
	input  videoPkg::xCoord                 dispX,
	input  logic                            romAck,
	input  logic [objPkg::romDataWidth-1:0] romData,
	output logic [7:0]                      cpuRdData,
	output logic                            lineDone,
	output logic                            romReq,
	output logic [objPkg::romAddrWidth-1:0] romAddr,
	output videoPkg::lineEntry              objPixel
);

	logic [$clog2(numObj)-1:0] scanIndex;
	objPkg::objAttr            scanAttr;

	// Draw job, scanner to fetcher
	logic                drawReq;
	logic                drawAck;
	objPkg::tileNum      drawTile;
	objPkg::objRow       drawRow;
	logic [2:0]          drawPalette;
	logic                drawFlip;
	videoPkg::xCoord     drawX;

	// Pixel writes into the draw buffer
	logic                wrEn;
	videoPkg::xCoord     wrX;
	videoPkg::lineEntry  wrEntry;

	objAttrRam #(.numObj(numObj)) i_objAttrRam (
		.clk, .cpuSel, .cpuWe, .cpuAddr, .cpuWrData, .scanIndex, .cpuRdData, .scanAttr
	);

	objLineScanner #(.numObj(numObj)) i_objLineScanner (
		.clk, .reset, .lineStart, .lineNum, .scanAttr, .drawAck, .scanIndex, .drawReq,
		.drawTile, .drawRow, .drawPalette, .drawFlip, .drawX, .lineDone
	);

	objPixelFetch i_objPixelFetch (
		.clk, .reset, .drawReq, .drawTile, .drawRow, .drawPalette, .drawFlip, .drawX,
		.romAck, .romData, .drawAck, .romReq, .romAddr, .wrEn, .wrX, .wrEntry
	);

	objLineBuffer i_objLineBuffer (
		.clk, .reset, .lineStart, .wrEn, .wrX, .wrEntry, .dispEn, .dispX, .objPixel
	);

endmodule

//--- objRomModel.sv
//--------------------
// Graphics ROM model for the testbench
// Req/ack responder with random latency
//--------------------

module objRomModel (
	input  logic        clk,
	input  logic        reset,
	input  logic        romReq,
	input  logic [16:0] romAddr,
	output logic        romAck,
	output logic [15:0] romData
);
	timeunit 1ns;
	timeprecision 100ps;

	logic [31:0] seed = 32'd46038;
	int          latency = 1;
	int          waitCnt = 0;

	function automatic logic [31:0] lcgNext(input logic [31:0] s);
		return s * 32'd1103515245 + 32'd12345;
	endfunction

	// Fixed hash of the address, one nibble per word forced transparent
	function automatic logic [15:0] romHash(input logic [16:0] a);
		logic [31:0] h;
		h = {15'd0, a} * 32'h9E3779B1;
		h[16 + 4 * (a[3:2] ^ a[1:0]) +: 4] = 4'h0;
		return h[31:16];
	endfunction

	initial begin
		romAck  = 1'b0;
		romData = '0;
	end

	// Answers change on the falling edge
	always @(negedge clk) begin
		if (reset) begin
			romAck <= 1'b0;
			waitCnt = 0;
		end else if (romAck) begin
			if (!romReq) begin   // Release phase, pick next latency
				romAck <= 1'b0;
				seed    = lcgNext(seed);
				latency = 1 + seed[23:16] % 6;
			end
		end else if (romReq) begin
			waitCnt = waitCnt + 1;
			if (waitCnt >= latency) begin
				romData <= romHash(romAddr);
				romAck  <= 1'b1;
				waitCnt = 0;
			end
		end
	end

endmodule

//--- objTopTb.sv
//--------------------
// Sprite engine testbench
// Clock, reset, CPU and line stimulus, ROM handshake monitor
//--------------------

module objTopTb;
	timeunit 1ns;
	timeprecision 100ps;

	localparam int numObj   = 128;
	localparam int lineWait = 20000;   // Cycles allowed per line

	logic        clk = 1'b0;
	logic        reset;
	logic        cpuSel;
	logic        cpuWe;
	logic [8:0]  cpuAddr;
	logic [7:0]  cpuWrData;
	logic [7:0]  cpuRdData;
	logic        lineStart;
	logic [7:0]  lineNum;
	logic        lineDone;
	logic        dispEn;
	logic [7:0]  dispX;
	logic [6:0]  objPixel;
	logic        romReq;
	logic        romAck;
	logic [16:0] romAddr;
	logic [15:0] romData;

	logic [7:0]  shadow [512];      // Expected attribute bytes
	logic [6:0]  expNext [256];     // Line being drawn
	logic [6:0]  expShown [256];    // Line on the display side
	logic [31:0] rnd = 32'd46038;
	int          errors = 0;
	int          checks = 0;
	int          linesRun = 0;
	bit          doneSeen = 1'b0;
	bit          timedOut = 1'b0;
	logic        reqQ;
	logic        ackQ;
	logic [16:0] addrQ;

	always #5 clk = ~clk;

	objTop #(.numObj(numObj)) i_objTop (
		.clk, .reset, .cpuSel, .cpuWe, .cpuAddr, .cpuWrData, .lineStart, .lineNum,
		.dispEn, .dispX, .romAck, .romData, .cpuRdData, .lineDone, .romReq, .romAddr,
		.objPixel
	);

	objRomModel i_objRomModel (.clk, .reset, .romReq, .romAddr, .romAck, .romData);

	function automatic logic [31:0] lcgNext(input logic [31:0] s);
		return s * 32'd1103515245 + 32'd12345;
	endfunction

	// Same address hash as the ROM model
	function automatic logic [15:0] romHash(input logic [16:0] a);
		logic [31:0] h;
		h = {15'd0, a} * 32'h9E3779B1;
		h[16 + 4 * (a[3:2] ^ a[1:0]) +: 4] = 4'h0;
		return h[31:16];
	endfunction

	task automatic flagError(input string msg);
		errors++;
		$display("error %0t: %s", $time, msg);
	endtask

	// --------------------
	// ROM handshake rules and lineDone capture
	always @(posedge clk) begin
		if (!reset) begin
			if (reqQ && romReq)
				assert (romAddr === addrQ) else flagError("romAddr changed while romReq high");
			if (reqQ && !romReq)
				assert (ackQ) else flagError("romReq fell before romAck");
			if (!reqQ && romReq)
				assert (!ackQ) else flagError("romReq rose while romAck high");
		end
		if (lineDone) doneSeen = 1'b1;   // Sticky until next lineStart
		reqQ  <= romReq;
		ackQ  <= romAck;
		addrQ <= romAddr;
	end

	// --------------------
	// CPU port tasks start and end on a falling edge
	task automatic cpuWrite(input logic [8:0] a, input logic [7:0] d);
		cpuSel    = 1'b1;
		cpuWe     = 1'b1;
		cpuAddr   = a;
		cpuWrData = d;
		shadow[a] = d;
		@(negedge clk);
		cpuSel = 1'b0;
		cpuWe  = 1'b0;
	endtask

	task automatic cpuReadCheck(input logic [8:0] a);
		cpuSel  = 1'b1;
		cpuWe   = 1'b0;
		cpuAddr = a;
		@(negedge clk);   // Registered read lands here
		cpuSel = 1'b0;
		checks++;
		assert (cpuRdData === shadow[a])
			else flagError($sformatf("cpuRdData %h at %h, expected %h", cpuRdData, a, shadow[a]));
	endtask

	task automatic setSprite(input int s, input logic [7:0] y, ctrl, tileLo, x);
		cpuWrite(9'(4 * s), y);
		cpuWrite(9'(4 * s + 1), ctrl);   // dh, flip, palette, tileHi
		cpuWrite(9'(4 * s + 2), tileLo);
		cpuWrite(9'(4 * s + 3), x);
	endtask

	// Expected line from the attribute bytes and the ROM hash
	task automatic buildExpected(input logic [7:0] line);
		logic [7:0]  row;
		logic [7:0]  b1;
		logic [7:0]  x;
		logic [10:0] tile;
		logic [15:0] w;
		logic [3:0]  c;
		for (int i = 0; i < 256; i++) expNext[i] = 7'd0;
		for (int s = 0; s < numObj; s++) begin   // Later sprite overwrites earlier
			b1  = shadow[4 * s + 1];
			row = line + shadow[4 * s];
			if (row < 16 || (row < 32 && b1[7])) begin
				tile = {b1[2:0], shadow[4 * s + 2]} + 11'(row >= 16);   // Lower half next tile
				for (int p = 0; p < 16; p++) begin
					w = romHash({tile, row[3:0], 2'(p / 4)});
					c = w[4 * (p % 4) +: 4];
					if (b1[6]) x = shadow[4 * s + 3] + 8'(15 - p);
					else x = shadow[4 * s + 3] + 8'(p);
					if (c != 4'd0) expNext[x] = {b1[5:3], c};
				end
			end
		end
	endtask

	// --------------------
	// Start a line, sweep the previous one and wait for lineDone
	task automatic runLine(input logic [7:0] num);
		int cnt;
		if (timedOut) return;
		buildExpected(num);
		lineNum   = num;
		lineStart = 1'b1;
		doneSeen  = 1'b0;
		@(negedge clk);
		lineStart = 1'b0;
		for (int x = 0; x < videoPkg::lineWidth; x++) begin
			dispEn = 1'b1;
			dispX  = 8'(x);
			@(negedge clk);
			if (linesRun >= 2) begin   // Warm-up buffers start undefined
				checks++;
				assert (objPixel === expShown[x])
					else flagError($sformatf("objPixel %h at x %0d, expected %h",
						objPixel, x, expShown[x]));
			end
		end
		dispEn = 1'b0;
		cnt    = 0;
		while (!doneSeen && cnt < lineWait) begin
			@(negedge clk);
			cnt++;
		end
		assert (doneSeen) else begin
			timedOut = 1'b1;
			$display("line %0d did not finish within %0d cycles", num, lineWait);
		end
		for (int i = 0; i < 256; i++) expShown[i] = expNext[i];
		linesRun++;
	endtask

	initial begin
		reset     = 1'b1;
		cpuSel    = 1'b0;
		cpuWe     = 1'b0;
		cpuAddr   = '0;
		cpuWrData = '0;
		lineStart = 1'b0;
		lineNum   = '0;
		dispEn    = 1'b0;
		dispX     = '0;
		repeat (16) @(negedge clk);
		reset = 1'b0;
		// Random bytes written, then read back
		for (int a = 0; a < 512; a++) begin
			rnd = lcgNext(rnd);
			cpuWrite(9'(a), rnd[23:16]);
		end
		for (int a = 0; a < 512; a++) cpuReadCheck(9'(a));
		for (int a = 0; a < 512; a++) cpuWrite(9'(a), 8'h00);   // Hits lines 0..15 only
		runLine(8'd60);
		runLine(8'd60);
		setSprite(5, 8'd159, 8'h11, 8'h23, 8'd40);     // Plain sprite on row 3
		setSprite(9, 8'd163, 8'h6A, 8'h5C, 8'd250);    // Flipped and wrapping past 255
		runLine(8'd100);
		setSprite(20, 8'd166, 8'h9C, 8'hFF, 8'd120);   // Double height on row 20
		runLine(8'd110);
		cpuWrite(9'(4 * 20 + 1), 8'h1C);               // Same sprite at normal height
		runLine(8'd110);
		setSprite(30, 8'd128, 8'h08, 8'h40, 8'd180);
		setSprite(31, 8'd135, 8'h33, 8'h41, 8'd186);   // Overlaps sprite 30
		runLine(8'd130);
		// Last of three empty lines rereads a buffer cleared on display
		runLine(8'd60);
		runLine(8'd60);
		runLine(8'd60);
		$display("checks %0d, errors %0d, timeout %0d", checks, errors, timedOut);
		if (errors == 0 && !timedOut) begin
			$display("TEST RESULT: PASS");
		end else begin
			$display("TEST RESULT: FAIL");
		end
		$finish;
	end

endmodule

//--- objTop.f
objPkg.sv
videoPkg.sv
objAttrRam.sv
objLineScanner.sv
objPixelFetch.sv
objLineBuffer.sv
objTop.sv
objRomModel.sv
objTopTb.sv
